/* Makefile */
TOP = tb_xm23_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f xm23_core.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TEST FAILED" sim.log
	grep -q "TEST OK" sim.log

lint:
	verilator --lint-only --top-module xm23_core xm23_isa_pkg.sv xm23_host_pkg.sv \
		xm23_op_if.sv xm23_apb_port.sv xm23_decoder.sv xm23_op_queue.sv \
		xm23_execute.sv xm23_core.sv

clean:
	rm -rf obj_dir sim.log

/* tb_xm23_core.sv */
`timescale 1ns/1ps

module tb_xm23_core;

	localparam int TIMEOUT_CYCLES = 200;

	logic clock;
	logic arst_n;
	xm23_host_pkg::apb_addr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	xm23_host_pkg::apb_data_t pwdata;
	xm23_host_pkg::apb_data_t prdata;
	logic pready;
	logic pslverr;

	xm23_isa_pkg::word_t model_regs [8];
	xm23_isa_pkg::word_t model_psw;
	logic [31:0] lfsr_state;
	xm23_isa_pkg::word_t rd_data;
	logic rd_err;
	int checks;
	int errors;
	int tests;
	int test_errors;

	xm23_core DUT (
		.clock(clock),
		.arst_n(arst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] value;
		logic fb;
		value = '0;
		for (int i = 0; i < count; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	function automatic xm23_isa_pkg::word_t constant_value(input logic [2:0] idx);
		case (idx)
			3'd0: return 16'h0000;
			3'd1: return 16'h0001;
			3'd2: return 16'h0002;
			3'd3: return 16'h0004;
			3'd4: return 16'h0008;
			3'd5: return 16'h0010;
			3'd6: return 16'h0020;
			default: return 16'hffff;
		endcase
	endfunction

	function automatic xm23_isa_pkg::word_t alu_word(input logic [7:0] opc, input logic rc,
		input logic wb, input logic [2:0] src, input logic [2:0] dst);
		return {opc, rc, wb, src, dst};
	endfunction

	function automatic xm23_isa_pkg::word_t move_word(input logic [4:0] prefix,
		input logic [7:0] value, input logic [2:0] dst);
		return {prefix, value, dst};
	endfunction

	function automatic xm23_isa_pkg::word_t random_alu_word();
		logic [7:0] opc;
		logic [31:0] r;
		r = rand_bits(3);
		case (r[2:0])
			3'd0, 3'd6: opc = 8'h40;
			3'd1, 3'd7: opc = 8'h42;
			3'd2: opc = 8'h46;
			3'd3: opc = 8'h47;
			3'd4: opc = 8'h48;
			default: opc = 8'h4c;
		endcase
		r = rand_bits(8);	// RC, WB, SRC, DST
		return {opc, r[7:0]};
	endfunction

	// Model of one instruction on model_regs and model_psw
	function automatic void xm23_ref_step(input xm23_isa_pkg::word_t instr);
		xm23_isa_pkg::word_t dv;
		xm23_isa_pkg::word_t sv;
		xm23_isa_pkg::word_t res;
		xm23_isa_pkg::word_t opnd;
		xm23_isa_pkg::word_t lres;
		logic [16:0] total;
		logic is_sub;
		logic sd;
		logic ss;
		logic sr;
		dv = model_regs[instr[2:0]];
		sv = instr[7] ? constant_value(instr[5:3]) : model_regs[instr[5:3]];
		res = dv;
		if (instr[15:11] == 5'b01100) begin
			res[7:0] = instr[10:3];
		end else if (instr[15:11] == 5'b01101) begin
			res = {8'h00, instr[10:3]};
		end else if (instr[15:11] == 5'b01111) begin
			res[15:8] = instr[10:3];
		end else begin
			case (instr[15:8])
				8'h40, 8'h42: begin
					is_sub = instr[15:8] == 8'h42;
					opnd = is_sub ? ~sv : sv;
					if (instr[6]) begin
						total = {9'h000, dv[7:0]} + {9'h000, opnd[7:0]} + {16'h0000, is_sub};
						res[7:0] = total[7:0];
						model_psw[xm23_isa_pkg::PSW_C] = total[8];
						model_psw[xm23_isa_pkg::PSW_Z] = total[7:0] == 8'h00;
						{sd, ss, sr} = {dv[7], sv[7], total[7]};
					end else begin
						total = {1'b0, dv} + {1'b0, opnd} + {16'h0000, is_sub};
						res = total[15:0];
						model_psw[xm23_isa_pkg::PSW_C] = total[16];
						model_psw[xm23_isa_pkg::PSW_Z] = total[15:0] == 16'h0000;
						{sd, ss, sr} = {dv[15], sv[15], total[15]};
					end
					model_psw[xm23_isa_pkg::PSW_N] = sr;
					// Overflow when the result sign differs from a same-sign sum
					model_psw[xm23_isa_pkg::PSW_V] = is_sub ? (sd != ss && sr != sd)
						: (sd == ss && sr != sd);
				end
				8'h46, 8'h47, 8'h48: begin
					if (instr[15:8] == 8'h46) begin
						lres = dv ^ sv;
					end else if (instr[15:8] == 8'h47) begin
						lres = dv & sv;
					end else begin
						lres = dv | sv;
					end
					if (instr[6]) begin
						res[7:0] = lres[7:0];
						model_psw[xm23_isa_pkg::PSW_Z] = lres[7:0] == 8'h00;
						model_psw[xm23_isa_pkg::PSW_N] = lres[7];
					end else begin
						res = lres;
						model_psw[xm23_isa_pkg::PSW_Z] = lres == 16'h0000;
						model_psw[xm23_isa_pkg::PSW_N] = lres[15];
					end
					model_psw[xm23_isa_pkg::PSW_C] = 1'b0;
					model_psw[xm23_isa_pkg::PSW_V] = 1'b0;
				end
				8'h4c: begin
					if (instr[6]) begin
						res[7:0] = sv[7:0];
					end else begin
						res = sv;
					end
				end
				8'h4d: begin
					if (instr[5:3] == 3'd3) begin
						res = {dv[7:0], dv[15:8]};
					end else if (instr[5:3] == 3'd4) begin
						res = {{8{dv[7]}}, dv[7:0]};
					end else begin
						return;	// Illegal
					end
				end
				default: return;	// Illegal
			endcase
		end
		model_regs[instr[2:0]] = res;
	endfunction

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("FAILED %s: got %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	// Setup, then access phase until pready seen at a falling edge
	task automatic apb_access(input xm23_host_pkg::apb_addr_t addr, input logic write,
		input xm23_host_pkg::apb_data_t wdata, output xm23_host_pkg::apb_data_t rdata,
		output logic err);
		int cycles;
		logic done;
		rdata = 'x;
		err = 1'bx;
		@(posedge clock);
		#2;
		paddr = addr;
		pwrite = write;
		pwdata = wdata;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge clock);
		#2;
		penable = 1'b1;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < TIMEOUT_CYCLES) begin
			@(negedge clock);
			if (pready === 1'b1) begin
				rdata = prdata;
				err = pslverr;
				done = 1'b1;
			end
			@(posedge clock);
			cycles++;
		end
		#2;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		if (!done) begin
			$display("APB access at address %h got no pready within %0d cycles",
				addr, TIMEOUT_CYCLES);
			errors++;
		end
	endtask

	task automatic exec_instr(input xm23_isa_pkg::word_t instr);
		apb_access(xm23_host_pkg::ADDR_INSTR, 1'b1, instr, rd_data, rd_err);
		check_value("pslverr", {15'h0000, rd_err}, 16'h0000);
		xm23_ref_step(instr);
	endtask

	task automatic read_value(input xm23_host_pkg::apb_addr_t addr);
		apb_access(addr, 1'b0, 16'h0000, rd_data, rd_err);
		check_value("pslverr", {15'h0000, rd_err}, 16'h0000);
	endtask

	task automatic wait_idle();
		int reads;
		logic busy;
		reads = 0;
		busy = 1'b1;
		while (busy && reads < TIMEOUT_CYCLES) begin
			apb_access(xm23_host_pkg::ADDR_STATUS, 1'b0, 16'h0000, rd_data, rd_err);
			busy = rd_data[xm23_host_pkg::STATUS_BUSY] !== 1'b0;
			reads++;
		end
		if (busy) begin
			$display("Busy bit still set after %0d status reads", TIMEOUT_CYCLES);
			errors++;
		end
	endtask

	task automatic check_state();
		for (int i = 0; i < 8; i++) begin
			read_value(xm23_host_pkg::ADDR_REG_BASE + xm23_host_pkg::apb_addr_t'(i * 4));
			check_value($sformatf("R%0d", i), rd_data, model_regs[i]);
		end
		read_value(xm23_host_pkg::ADDR_PSW);
		check_value("PSW", rd_data, model_psw);
	endtask

	task automatic run_and_check(input xm23_isa_pkg::word_t instr);
		exec_instr(instr);
		wait_idle();
		check_state();
	endtask

	task automatic start_test();
		test_errors = errors;
		tests++;
	endtask

	task automatic end_test(input string name);
		$display("test %0d %s: %0d errors", tests, name, errors - test_errors);
	endtask

	initial begin
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		arst_n = 1'b0;
		lfsr_state = 32'h47c4_3672;
		model_psw = '0;
		checks = 0;
		errors = 0;
		tests = 0;
		for (int i = 0; i < 8; i++) begin
			model_regs[i] = '0;
		end
		repeat (8) @(posedge clock);
		#2;
		arst_n = 1'b1;

		start_test();
		read_value(xm23_host_pkg::ADDR_STATUS);
		check_value("STATUS", rd_data, 16'h0000);
		check_state();
		end_test("reset_values");

		start_test();
		for (int i = 0; i < 8; i++) begin
			exec_instr(move_word(5'b01101, 8'(rand_bits(8)), 3'(i)));
			exec_instr(move_word(5'b01111, 8'(rand_bits(8)), 3'(i)));
			if (i % 2 == 1) begin
				exec_instr(move_word(5'b01100, 8'(rand_bits(8)), 3'(i)));
			end
		end
		wait_idle();
		check_state();
		end_test("move_immediate");

		start_test();
		for (int n = 0; n < 200; n++) begin
			exec_instr(random_alu_word());
		end
		wait_idle();
		check_state();
		end_test("random_alu");

		start_test();
		exec_instr(move_word(5'b01101, 8'h80, 3'd1));
		exec_instr(move_word(5'b01111, 8'h12, 3'd1));
		run_and_check(alu_word(8'h4d, 1'b0, 1'b0, 3'd3, 3'd1));	// SWPB R1
		exec_instr(move_word(5'b01101, 8'h85, 3'd2));
		run_and_check(alu_word(8'h4d, 1'b0, 1'b0, 3'd4, 3'd2));	// SXT R2
		exec_instr(move_word(5'b01101, 8'h7f, 3'd3));
		exec_instr(move_word(5'b01111, 8'h01, 3'd3));
		exec_instr(move_word(5'b01101, 8'h01, 3'd4));
		run_and_check(alu_word(8'h40, 1'b0, 1'b1, 3'd4, 3'd3));	// ADD.B overflows
		exec_instr(move_word(5'b01101, 8'h00, 3'd5));
		run_and_check(alu_word(8'h42, 1'b1, 1'b1, 3'd1, 3'd5));	// SUB.B #1 borrows
		exec_instr(move_word(5'b01101, 8'h00, 3'd6));
		exec_instr(move_word(5'b01111, 8'hff, 3'd6));
		run_and_check(alu_word(8'h46, 1'b1, 1'b1, 3'd7, 3'd6));	// XOR.B #FFFF
		exec_instr(move_word(5'b01101, 8'hff, 3'd7));
		exec_instr(move_word(5'b01111, 8'hff, 3'd7));
		run_and_check(alu_word(8'h40, 1'b1, 1'b0, 3'd1, 3'd7));	// Wraps to zero with carry
		run_and_check(alu_word(8'h4c, 1'b0, 1'b1, 3'd1, 3'd4));	// MOV.B keeps flags
		end_test("directed_ops");

		start_test();
		exec_instr(16'h0000);
		exec_instr(16'h4d00);	// 4D with SRC 0
		exec_instr(16'h7000);
		wait_idle();
		read_value(xm23_host_pkg::ADDR_STATUS);
		check_value("STATUS", rd_data, 16'h0002);
		check_state();
		apb_access(xm23_host_pkg::ADDR_STATUS, 1'b1, 16'h1234, rd_data, rd_err);
		check_value("pslverr", {15'h0000, rd_err}, 16'h0000);
		read_value(xm23_host_pkg::ADDR_STATUS);
		check_value("STATUS", rd_data, 16'h0000);
		end_test("illegal_word");

		start_test();
		apb_access(8'h10, 1'b0, 16'h0000, rd_data, rd_err);	// Unmapped
		check_value("pslverr", {15'h0000, rd_err}, 16'h0001);
		apb_access(xm23_host_pkg::ADDR_INSTR, 1'b0, 16'h0000, rd_data, rd_err);
		check_value("pslverr", {15'h0000, rd_err}, 16'h0001);
		apb_access(xm23_host_pkg::ADDR_PSW, 1'b1, 16'h001f, rd_data, rd_err);
		check_value("pslverr", {15'h0000, rd_err}, 16'h0001);
		apb_access(xm23_host_pkg::ADDR_REG_BASE, 1'b1, 16'hbeef, rd_data, rd_err);
		check_value("pslverr", {15'h0000, rd_err}, 16'h0001);
		check_state();
		end_test("bus_errors");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* xm23_apb_port.sv */
`timescale 1ns/1ps

module xm23_apb_port (
	input logic clock,
	input logic arst_n,
	input xm23_host_pkg::apb_addr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input xm23_host_pkg::apb_data_t pwdata,
	input logic instr_ready,
	input logic dec_pending,
	input logic queue_pending,
	input logic exe_busy,
	input logic illegal_pulse,
	input xm23_isa_pkg::word_t reg_rd_data,
	input xm23_isa_pkg::word_t psw,
	output xm23_host_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output xm23_isa_pkg::word_t instr_word,
	output logic instr_valid,
	output xm23_isa_pkg::reg_num_t reg_rd_sel
);

	logic access;
	logic is_instr;
	logic is_status;
	logic is_psw;
	logic is_reg;
	logic addr_err;
	logic illegal_flag;

	assign access = psel && penable;

	assign is_instr = paddr == xm23_host_pkg::ADDR_INSTR;
	assign is_status = paddr == xm23_host_pkg::ADDR_STATUS;
	assign is_psw = paddr == xm23_host_pkg::ADDR_PSW;
	assign is_reg = (paddr[7:5] == xm23_host_pkg::ADDR_REG_BASE[7:5]) && (paddr[1:0] == 2'b00);

	// Unmapped, instruction read, or write to a read-only location
	assign addr_err = !(is_instr || is_status || is_psw || is_reg)
		|| (is_instr && !pwrite)
		|| (pwrite && (is_psw || is_reg));

	assign instr_word = pwdata;
	assign instr_valid = access && pwrite && is_instr;
	assign reg_rd_sel = paddr[4:2];

	assign pready = access && (!instr_valid || instr_ready);	// Stall until decoder takes word
	assign pslverr = access && addr_err;

	always_comb begin
		prdata = '0;
		if (!pwrite && !addr_err) begin
			if (is_status) begin
				prdata[xm23_host_pkg::STATUS_BUSY] = dec_pending || queue_pending || exe_busy;
				prdata[xm23_host_pkg::STATUS_ILLEGAL] = illegal_flag;
			end else if (is_psw) begin
				prdata = psw;
			end else begin
				prdata = reg_rd_data;
			end
		end
	end

	// A new illegal word wins over a clear in the same cycle
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			illegal_flag <= 1'b0;
		end else if (illegal_pulse) begin
			illegal_flag <= 1'b1;
		end else if (access && pwrite && is_status) begin
			illegal_flag <= 1'b0;
		end
	end

endmodule

/* xm23_core.f */
xm23_isa_pkg.sv
xm23_host_pkg.sv
xm23_op_if.sv
xm23_apb_port.sv
xm23_decoder.sv
xm23_op_queue.sv
xm23_execute.sv
xm23_core.sv
xm23_core_checker.sv
tb_xm23_core.sv

/* xm23_core.sv */
`timescale 1ns/1ps

module xm23_core (
	input logic clock,
	input logic arst_n,
	input xm23_host_pkg::apb_addr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input xm23_host_pkg::apb_data_t pwdata,
	output xm23_host_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr
);

	xm23_isa_pkg::word_t instr_word;
	logic instr_valid;
	logic instr_ready;
	logic dec_pending;
	logic queue_pending;
	logic exe_busy;
	logic illegal_pulse;
	xm23_isa_pkg::reg_num_t reg_rd_sel;
	xm23_isa_pkg::word_t reg_rd_data;
	xm23_isa_pkg::word_t psw;

	xm23_op_if dec_if ();	// Decoder to queue
	xm23_op_if exe_if ();	// Queue to execute unit

	xm23_apb_port u_apb_port (
		.clock(clock),
		.arst_n(arst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.instr_ready(instr_ready),
		.dec_pending(dec_pending),
		.queue_pending(queue_pending),
		.exe_busy(exe_busy),
		.illegal_pulse(illegal_pulse),
		.reg_rd_data(reg_rd_data),
		.psw(psw),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.instr_word(instr_word),
		.instr_valid(instr_valid),
		.reg_rd_sel(reg_rd_sel)
	);

	xm23_decoder u_decoder (
		.clock(clock),
		.arst_n(arst_n),
		.instr_word(instr_word),
		.instr_valid(instr_valid),
		.instr_ready(instr_ready),
		.dec_pending(dec_pending),
		.illegal_pulse(illegal_pulse),
		.dec_if(dec_if.producer)
	);

	xm23_op_queue #(
		.DEPTH(xm23_host_pkg::QUEUE_DEPTH_DEFAULT)
	) u_op_queue (
		.clock(clock),
		.arst_n(arst_n),
		.dec_if(dec_if.consumer),
		.exe_if(exe_if.producer),
		.queue_pending(queue_pending)
	);

	xm23_execute u_execute (
		.clock(clock),
		.arst_n(arst_n),
		.exe_if(exe_if.consumer),
		.reg_rd_sel(reg_rd_sel),
		.reg_rd_data(reg_rd_data),
		.psw(psw),
		.exe_busy(exe_busy)
	);

endmodule

/* xm23_core_checker.sv */
`timescale 1ns/1ps

module xm23_core_checker (
	input logic clock,
	input logic arst_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic exe_valid,
	input logic exe_ready,
	input xm23_isa_pkg::xm23_op_e exe_op,
	input xm23_isa_pkg::reg_num_t exe_dst,
	input xm23_isa_pkg::reg_num_t exe_src,
	input logic exe_rc,
	input logic exe_wb,
	input xm23_isa_pkg::byte_t exe_imm
);

	logic [19:0] exe_payload;

	assign exe_payload = {exe_op, exe_dst, exe_src, exe_rc, exe_wb, exe_imm};

	ready_in_access: assert property (@(posedge clock) disable iff (!arst_n)
		pready |-> (psel && penable))
		else $error("pready outside an APB access phase");

	error_with_ready: assert property (@(posedge clock) disable iff (!arst_n)
		pslverr |-> pready)
		else $error("pslverr without pready");

	// Head of the queue must hold until the execute unit takes it
	exe_op_stable: assert property (@(posedge clock) disable iff (!arst_n)
		(exe_valid && !exe_ready) |=> (exe_valid && $stable(exe_payload)))
		else $error("exe_if valid or payload changed before ready");

endmodule

bind xm23_core xm23_core_checker u_checker (
	.clock(clock),
	.arst_n(arst_n),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.pslverr(pslverr),
	.exe_valid(exe_if.valid),
	.exe_ready(exe_if.ready),
	.exe_op(exe_if.op),
	.exe_dst(exe_if.dst),
	.exe_src(exe_if.src),
	.exe_rc(exe_if.rc),
	.exe_wb(exe_if.wb),
	.exe_imm(exe_if.imm)
);

/* xm23_decoder.sv */
`timescale 1ns/1ps

module xm23_decoder (
	input logic clock,
	input logic arst_n,
	input xm23_isa_pkg::word_t instr_word,
	input logic instr_valid,
	output logic instr_ready,
	output logic dec_pending,
	output logic illegal_pulse,
	xm23_op_if.producer dec_if
);

	xm23_isa_pkg::xm23_op_e dec_op;
	logic dec_legal;
	logic take;

	assign instr_ready = !dec_if.valid || dec_if.ready;	// Empty or draining this cycle
	assign take = instr_valid && instr_ready;
	assign dec_pending = dec_if.valid;

	always_comb begin
		dec_op = xm23_isa_pkg::OP_MOV;
		dec_legal = 1'b1;
		case (instr_word[15:11])
			xm23_isa_pkg::PREFIX_MOVL: dec_op = xm23_isa_pkg::OP_MOVL;
			xm23_isa_pkg::PREFIX_MOVLZ: dec_op = xm23_isa_pkg::OP_MOVLZ;
			xm23_isa_pkg::PREFIX_MOVH: dec_op = xm23_isa_pkg::OP_MOVH;
			default: begin
				case (instr_word[15:8])
					xm23_isa_pkg::OPCODE_ADD: dec_op = xm23_isa_pkg::OP_ADD;
					xm23_isa_pkg::OPCODE_SUB: dec_op = xm23_isa_pkg::OP_SUB;
					xm23_isa_pkg::OPCODE_XOR: dec_op = xm23_isa_pkg::OP_XOR;
					xm23_isa_pkg::OPCODE_AND: dec_op = xm23_isa_pkg::OP_AND;
					xm23_isa_pkg::OPCODE_OR: dec_op = xm23_isa_pkg::OP_OR;
					xm23_isa_pkg::OPCODE_MOV: dec_op = xm23_isa_pkg::OP_MOV;
					xm23_isa_pkg::OPCODE_SWPB_SXT: begin
						if (instr_word[5:3] == xm23_isa_pkg::SRC_SWPB) begin
							dec_op = xm23_isa_pkg::OP_SWPB;
						end else if (instr_word[5:3] == xm23_isa_pkg::SRC_SXT) begin
							dec_op = xm23_isa_pkg::OP_SXT;
						end else begin
							dec_legal = 1'b0;
						end
					end
					default: dec_legal = 1'b0;
				endcase
			end
		endcase
	end

	// Illegal words are consumed and dropped here
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			dec_if.valid <= 1'b0;
			illegal_pulse <= 1'b0;
		end else begin
			illegal_pulse <= take && !dec_legal;
			if (take && dec_legal) begin
				dec_if.valid <= 1'b1;
			end else if (dec_if.ready) begin
				dec_if.valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take && dec_legal) begin
			dec_if.op <= dec_op;
			dec_if.dst <= instr_word[2:0];
			dec_if.src <= instr_word[5:3];
			dec_if.rc <= instr_word[7];
			dec_if.wb <= instr_word[6];
			dec_if.imm <= instr_word[10:3];	// Only meaningful for MOVx
		end
	end

endmodule

/* xm23_execute.sv */
`timescale 1ns/1ps

module xm23_execute (
	input logic clock,
	input logic arst_n,
	xm23_op_if.consumer exe_if,
	input xm23_isa_pkg::reg_num_t reg_rd_sel,
	output xm23_isa_pkg::word_t reg_rd_data,
	output xm23_isa_pkg::word_t psw,
	output logic exe_busy
);

	typedef enum logic [1:0] {ST_IDLE, ST_OPERAND, ST_ALU, ST_WRITE} exe_state_e;

	exe_state_e state;
	xm23_isa_pkg::word_t regs [xm23_isa_pkg::NUM_REGS];
	xm23_isa_pkg::xm23_op_e op_q;
	xm23_isa_pkg::reg_num_t dst_q;
	logic wb_q;
	xm23_isa_pkg::byte_t imm_q;
	xm23_isa_pkg::word_t dst_val;
	xm23_isa_pkg::word_t src_val;
	xm23_isa_pkg::word_t result_q;
	xm23_isa_pkg::word_t psw_new_q;
	xm23_isa_pkg::word_t result;
	xm23_isa_pkg::word_t psw_new;
	xm23_isa_pkg::word_t addend;
	xm23_isa_pkg::word_t logic_res;
	logic carry_in;
	logic [16:0] sum_w;
	logic [8:0] sum_b;
	logic accept;

	assign exe_if.ready = state == ST_IDLE;
	assign accept = exe_if.valid && exe_if.ready;
	assign exe_busy = state != ST_IDLE;
	assign reg_rd_data = regs[reg_rd_sel];

	// SUB is dst + ~src + 1
	assign carry_in = op_q == xm23_isa_pkg::OP_SUB;
	assign addend = carry_in ? ~src_val : src_val;
	assign sum_w = {1'b0, dst_val} + {1'b0, addend} + {16'h0000, carry_in};
	assign sum_b = {1'b0, dst_val[7:0]} + {1'b0, addend[7:0]} + {8'h00, carry_in};

	always_comb begin
		case (op_q)
			xm23_isa_pkg::OP_AND: logic_res = dst_val & src_val;
			xm23_isa_pkg::OP_OR: logic_res = dst_val | src_val;
			default: logic_res = dst_val ^ src_val;
		endcase
	end

	always_comb begin
		result = dst_val;
		psw_new = psw;
		case (op_q)
			xm23_isa_pkg::OP_ADD, xm23_isa_pkg::OP_SUB: begin
				if (wb_q) begin
					result[7:0] = sum_b[7:0];	// High byte of dst kept
					psw_new[xm23_isa_pkg::PSW_C] = sum_b[8];
					psw_new[xm23_isa_pkg::PSW_Z] = sum_b[7:0] == 8'h00;
					psw_new[xm23_isa_pkg::PSW_N] = sum_b[7];
					psw_new[xm23_isa_pkg::PSW_V] = (dst_val[7] == addend[7]) && (sum_b[7] != dst_val[7]);
				end else begin
					result = sum_w[15:0];
					psw_new[xm23_isa_pkg::PSW_C] = sum_w[16];
					psw_new[xm23_isa_pkg::PSW_Z] = sum_w[15:0] == 16'h0000;
					psw_new[xm23_isa_pkg::PSW_N] = sum_w[15];
					psw_new[xm23_isa_pkg::PSW_V] = (dst_val[15] == addend[15]) && (sum_w[15] != dst_val[15]);
				end
			end
			xm23_isa_pkg::OP_XOR, xm23_isa_pkg::OP_AND, xm23_isa_pkg::OP_OR: begin
				psw_new[xm23_isa_pkg::PSW_C] = 1'b0;
				psw_new[xm23_isa_pkg::PSW_V] = 1'b0;
				if (wb_q) begin
					result[7:0] = logic_res[7:0];
					psw_new[xm23_isa_pkg::PSW_Z] = logic_res[7:0] == 8'h00;
					psw_new[xm23_isa_pkg::PSW_N] = logic_res[7];
				end else begin
					result = logic_res;
					psw_new[xm23_isa_pkg::PSW_Z] = logic_res == 16'h0000;
					psw_new[xm23_isa_pkg::PSW_N] = logic_res[15];
				end
			end
			xm23_isa_pkg::OP_MOV: begin
				if (wb_q) begin
					result[7:0] = src_val[7:0];
				end else begin
					result = src_val;
				end
			end
			xm23_isa_pkg::OP_SWPB: result = {dst_val[7:0], dst_val[15:8]};
			xm23_isa_pkg::OP_SXT: result = {{8{dst_val[7]}}, dst_val[7:0]};
			xm23_isa_pkg::OP_MOVL: result[7:0] = imm_q;
			xm23_isa_pkg::OP_MOVLZ: result = {8'h00, imm_q};
			xm23_isa_pkg::OP_MOVH: result[15:8] = imm_q;
			default: result = dst_val;
		endcase
	end

	// Accept, compute, write back, then one cycle before ready again
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			psw <= '0;
			for (int i = 0; i < xm23_isa_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept) begin
						state <= ST_OPERAND;
					end
				end
				ST_OPERAND: state <= ST_ALU;
				ST_ALU: begin
					state <= ST_WRITE;
					regs[dst_q] <= result_q;
					psw <= psw_new_q;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			op_q <= exe_if.op;
			dst_q <= exe_if.dst;
			wb_q <= exe_if.wb;
			imm_q <= exe_if.imm;
			dst_val <= regs[exe_if.dst];
			src_val <= exe_if.rc ? xm23_isa_pkg::CON_TABLE[exe_if.src] : regs[exe_if.src];
		end
		if (state == ST_OPERAND) begin
			result_q <= result;
			psw_new_q <= psw_new;
		end
	end

endmodule

/* xm23_host_pkg.sv */
package xm23_host_pkg;

	localparam int APB_ADDR_W = 8;
	localparam int APB_DATA_W = 16;

	typedef logic [APB_ADDR_W-1:0] apb_addr_t;
	typedef logic [APB_DATA_W-1:0] apb_data_t;

	// Register n sits at ADDR_REG_BASE + 4*n
	localparam apb_addr_t ADDR_INSTR = 8'h00;
	localparam apb_addr_t ADDR_STATUS = 8'h04;
	localparam apb_addr_t ADDR_PSW = 8'h08;
	localparam apb_addr_t ADDR_REG_BASE = 8'h20;

	localparam int STATUS_BUSY = 0;
	localparam int STATUS_ILLEGAL = 1;

	localparam int QUEUE_DEPTH_DEFAULT = 4;

endpackage

/* xm23_isa_pkg.sv */
package xm23_isa_pkg;

	localparam int WORD_W = 16;
	localparam int BYTE_W = 8;
	localparam int REG_NUM_W = 3;
	localparam int PREFIX_W = 5;	// Top bits that select MOVL, MOVLZ, MOVH
	localparam int NUM_REGS = 8;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [REG_NUM_W-1:0] reg_num_t;

	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_XOR,
		OP_AND,
		OP_OR,
		OP_MOV,
		OP_SWPB,
		OP_SXT,
		OP_MOVL,
		OP_MOVLZ,
		OP_MOVH
	} xm23_op_e;

	// PSW flag positions
	localparam int PSW_C = 0;
	localparam int PSW_Z = 1;
	localparam int PSW_N = 2;
	localparam int PSW_V = 4;

	// Values selected by SRC/CON when RC is set
	localparam word_t CON_TABLE [NUM_REGS] = '{
		16'h0000, 16'h0001, 16'h0002, 16'h0004,
		16'h0008, 16'h0010, 16'h0020, 16'hffff
	};

	// Opcode byte, instruction bits 15-8
	localparam byte_t OPCODE_ADD = 8'h40;
	localparam byte_t OPCODE_SUB = 8'h42;
	localparam byte_t OPCODE_XOR = 8'h46;
	localparam byte_t OPCODE_AND = 8'h47;
	localparam byte_t OPCODE_OR = 8'h48;
	localparam byte_t OPCODE_MOV = 8'h4c;
	localparam byte_t OPCODE_SWPB_SXT = 8'h4d;	// Split by the SRC field

	localparam reg_num_t SRC_SWPB = 3'd3;
	localparam reg_num_t SRC_SXT = 3'd4;

	// Bits 15-11 of the move-immediate group
	localparam logic [PREFIX_W-1:0] PREFIX_MOVL = 5'b01100;
	localparam logic [PREFIX_W-1:0] PREFIX_MOVLZ = 5'b01101;
	localparam logic [PREFIX_W-1:0] PREFIX_MOVH = 5'b01111;

endpackage

/* xm23_op_if.sv */
`timescale 1ns/1ps

interface xm23_op_if;

	logic valid;
	logic ready;
	xm23_isa_pkg::xm23_op_e op;
	xm23_isa_pkg::reg_num_t dst;
	xm23_isa_pkg::reg_num_t src;	// Register or constant index
	logic rc;
	logic wb;
	xm23_isa_pkg::byte_t imm;	// MOVL/MOVLZ/MOVH byte

	modport producer (
		output valid, op, dst, src, rc, wb, imm,
		input ready
	);

	modport consumer (
		input valid, op, dst, src, rc, wb, imm,
		output ready
	);

endinterface

/* xm23_op_queue.sv */
`timescale 1ns/1ps

module xm23_op_queue #(
	parameter int DEPTH = xm23_host_pkg::QUEUE_DEPTH_DEFAULT
) (
	input logic clock,
	input logic arst_n,
	xm23_op_if.consumer dec_if,
	xm23_op_if.producer exe_if,
	output logic queue_pending
);

	typedef logic [$clog2(DEPTH)-1:0] ptr_t;
	typedef logic [$clog2(DEPTH+1)-1:0] count_t;

	xm23_isa_pkg::xm23_op_e mem_op [DEPTH];
	xm23_isa_pkg::reg_num_t mem_dst [DEPTH];
	xm23_isa_pkg::reg_num_t mem_src [DEPTH];
	logic mem_rc [DEPTH];
	logic mem_wb [DEPTH];
	xm23_isa_pkg::byte_t mem_imm [DEPTH];

	ptr_t wr_ptr;
	ptr_t rd_ptr;
	count_t count;
	logic push;
	logic pop;

	assign dec_if.ready = count != count_t'(DEPTH);	// No fall-through when full
	assign exe_if.valid = count != '0;
	assign queue_pending = count != '0;

	assign push = dec_if.valid && dec_if.ready;
	assign pop = exe_if.valid && exe_if.ready;

	assign exe_if.op = mem_op[rd_ptr];
	assign exe_if.dst = mem_dst[rd_ptr];
	assign exe_if.src = mem_src[rd_ptr];
	assign exe_if.rc = mem_rc[rd_ptr];
	assign exe_if.wb = mem_wb[rd_ptr];
	assign exe_if.imm = mem_imm[rd_ptr];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			mem_op[wr_ptr] <= dec_if.op;
			mem_dst[wr_ptr] <= dec_if.dst;
			mem_src[wr_ptr] <= dec_if.src;
			mem_rc[wr_ptr] <= dec_if.rc;
			mem_wb[wr_ptr] <= dec_if.wb;
			mem_imm[wr_ptr] <= dec_if.imm;
		end
	end

endmodule
